//--- run_sim.sh
#!/usr/bin/env bash
# Build the video subsystem testbench with Verilator and run it.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_video_subsys \
    -f video_subsys.f \
    --Mdir obj_dir -o sim_video \
    && ./obj_dir/sim_video > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "All checks passed" sim.log 2>/dev/null \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

//--- src/axil_vregs.sv
//////////////////////////////
// AXI4-Lite register front end
// Control, status and RAM writes
//////////////////////////////
module axil_vregs (
    input  logic                  clk,
    input  logic                  rst_n,
    // Write address and data
    input  video_pkg::axi_addr_t  awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  video_pkg::axi_data_t  wdata,
    input  logic                  wvalid,
    output logic                  wready,
    // Write response
    output video_pkg::axi_resp_t  bresp,
    output logic                  bvalid,
    input  logic                  bready,
    // Read address and data
    input  video_pkg::axi_addr_t  araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output video_pkg::axi_data_t  rdata,
    output video_pkg::axi_resp_t  rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // Video side
    input  logic                  vblank,
    output video_pkg::vram_wr_t   vram_wr,
    output video_pkg::vctrl_t     ctrl
);

    typedef enum logic {W_IDLE, W_RESP} wr_state_t;
    typedef enum logic {R_IDLE, R_RESP} rd_state_t;

    wr_state_t         wr_state;
    rd_state_t         rd_state;
    logic              wr_accept;
    logic              aw_map;
    logic              aw_pal;
    logic              aw_ctrl;
    logic              wr_valid;
    logic              wr_sel;
    logic [7:0]        wr_addr;
    video_pkg::rgb_t   wr_data;

    // Address decode, low two bits ignored inside the RAM windows
    assign aw_map  = awaddr[11:10] == video_pkg::MAP_BASE[11:10];
    assign aw_pal  = awaddr[11:6]  == video_pkg::PAL_BASE[11:6];
    assign aw_ctrl = awaddr        == video_pkg::CTRL_ADDR;

    // Address and data taken together, only with no response pending
    assign awready   = (wr_state == W_IDLE) && awvalid && wvalid;
    assign wready    = awready;
    assign wr_accept = awready;
    assign bvalid    = wr_state == W_RESP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= W_IDLE;
            wr_valid <= 1'b0;
            ctrl     <= '0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (bready) begin
                        wr_state <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
            wr_valid <= wr_accept && (aw_map || aw_pal);
            if (wr_accept && aw_ctrl) begin
                ctrl <= video_pkg::vctrl_t'(wdata[9:0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_sel  <= aw_pal ? video_pkg::SEL_PAL : video_pkg::SEL_MAP;
            wr_addr <= aw_pal ? {4'd0, awaddr[5:2]} : awaddr[9:2];
            wr_data <= wdata[14:0];
            bresp   <= (aw_map || aw_pal || aw_ctrl) ? video_pkg::RESP_OKAY
                                                     : video_pkg::RESP_SLVERR;
        end
    end

    assign vram_wr = '{valid: wr_valid, sel: wr_sel, addr: wr_addr, data: wr_data};

    // Read side, only control and status are visible
    assign arready = (rd_state == R_IDLE) && arvalid;
    assign rvalid  = rd_state == R_RESP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= R_IDLE;
        end else if (rd_state == R_IDLE) begin
            if (arready) begin
                rd_state <= R_RESP;
            end
        end else if (rready) begin
            rd_state <= R_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            if (araddr == video_pkg::CTRL_ADDR) begin
                rdata <= {22'd0, ctrl};
                rresp <= video_pkg::RESP_OKAY;
            end else if (araddr == video_pkg::STAT_ADDR) begin
                rdata <= {31'd0, vblank};
                rresp <= video_pkg::RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= video_pkg::RESP_SLVERR;
            end
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else $error("rvalid dropped before rready");

endmodule

//--- src/colour_mix.sv
//////////////////////////////
// Colour mixer
// Palette lookup, layer enable, blanking
//////////////////////////////
module colour_mix (
    input  logic                 clk,
    input  logic                 rst_n,
    input  video_pkg::pix_idx_t  pix_in,
    input  video_pkg::vctrl_t    ctrl,
    input  video_pkg::vram_wr_t  vram_wr,
    output video_pkg::rgb_t      rgb,
    output logic                 de,
    output logic                 hsync,
    output logic                 vsync
);

    video_pkg::rgb_t     pal_ram [16];
    video_pkg::rgb_t     backdrop;
    video_pkg::rgb_t     pal1;
    video_pkg::col_idx_t pal_waddr;
    logic                pal_we;
    logic                de1;
    logic                hs1;
    logic                vs1;

    assign pal_we    = vram_wr.valid && (vram_wr.sel == video_pkg::SEL_PAL);
    assign pal_waddr = vram_wr.addr[3:0];

    // Entry 0 is also kept aside as the backdrop colour
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_waddr] <= vram_wr.data;
            if (pal_waddr == '0) begin
                backdrop <= vram_wr.data;
            end
        end
    end

    // Stage one, palette read
    always_ff @(posedge clk) begin
        pal1 <= pal_ram[pix_in.idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de1 <= 1'b0;
            hs1 <= 1'b0;
            vs1 <= 1'b0;
        end else begin
            de1 <= pix_in.tim.de;
            hs1 <= pix_in.tim.hsync;
            vs1 <= pix_in.tim.vsync;
        end
    end

    // Output register, black outside the active area
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb   <= '0;
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            de    <= de1;
            hsync <= hs1;
            vsync <= vs1;
            if (!de1) begin
                rgb <= '0;
            end else begin
                rgb <= ctrl.layer_en ? pal1 : backdrop;
            end
        end
    end

    a_blank_black: assert property (
        @(posedge clk) disable iff (!rst_n)
        !de |-> rgb == '0
    ) else $error("colour output outside active area");

endmodule

//--- src/tile_render.sv
//////////////////////////////
// Tile renderer
// Map lookup, scroll, flip, checker tiles
//////////////////////////////
module tile_render #(
    parameter int H_ACTIVE = 320
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  video_pkg::timing_t   timing_in,
    input  video_pkg::vctrl_t    ctrl,
    input  video_pkg::vram_wr_t  vram_wr,
    output video_pkg::pix_idx_t  pix_out
);

    video_pkg::tile_entry_t map_ram [256];

    video_pkg::coord_t      x_eff;
    logic [7:0]             u;
    logic [7:0]             map_addr;
    logic                   map_we;

    // Stage one
    video_pkg::timing_t     t1;
    video_pkg::tile_entry_t entry1;
    logic                   fg1;

    // Stage two
    video_pkg::timing_t     t2;
    video_pkg::col_idx_t    idx2;

    assign map_we = vram_wr.valid && (vram_wr.sel == video_pkg::SEL_MAP);

    always_ff @(posedge clk) begin
        if (map_we) begin
            map_ram[vram_wr.addr] <= vram_wr.data[7:0];
        end
    end

    // Flip mirrors the column around the active width
    assign x_eff = ctrl.flip ? video_pkg::coord_t'(H_ACTIVE - 1) - timing_in.x
                             : timing_in.x;

    // Scroll wraps at 256, the width of the map
    assign u = x_eff[7:0] + ctrl.scroll_x;

    // Row of the tile from y, column from u
    assign map_addr = {timing_in.y[video_pkg::TILE_SHIFT +: video_pkg::MAP_ROW_BITS],
                       u[video_pkg::TILE_SHIFT +: video_pkg::MAP_COL_BITS]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            t1 <= '0;
        end else begin
            t1 <= timing_in;
        end
    end

    always_ff @(posedge clk) begin
        entry1 <= map_ram[map_addr];
        // Checker of 4x4 squares inside each tile
        fg1    <= u[video_pkg::TILE_SHIFT - 1] ^ timing_in.y[video_pkg::TILE_SHIFT - 1];
    end

    // Pick foreground or background nibble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            t2 <= '0;
        end else begin
            t2 <= t1;
        end
    end

    always_ff @(posedge clk) begin
        idx2 <= fg1 ? entry1[7:4] : entry1[3:0];
    end

    assign pix_out = '{tim: t2, idx: idx2};

endmodule

//--- src/video_pkg.sv
//////////////////////////////
// Video subsystem package
// Shared widths, pixel words and address map
//////////////////////////////
package video_pkg;

    // Widths with a meaning of their own
    typedef logic [9:0]  coord_t;
    typedef logic [7:0]  tile_entry_t;
    typedef logic [3:0]  col_idx_t;
    typedef logic [14:0] rgb_t;
    typedef logic [11:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    // Timing word that follows each pixel down the pipeline
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   de;
        logic   hsync;
        logic   vsync;
    } timing_t;

    typedef struct packed {
        timing_t  tim;
        col_idx_t idx;
    } pix_idx_t;

    // One-cycle RAM write request from the bus
    typedef struct packed {
        logic       valid;
        logic       sel;
        logic [7:0] addr;
        rgb_t       data;
    } vram_wr_t;

    localparam logic SEL_MAP = 1'b0;
    localparam logic SEL_PAL = 1'b1;

    // Bit layout: scroll_x 7:0, flip 8, layer_en 9
    typedef struct packed {
        logic       layer_en;
        logic       flip;
        logic [7:0] scroll_x;
    } vctrl_t;

    localparam axi_addr_t MAP_BASE  = 12'h000;
    localparam axi_addr_t PAL_BASE  = 12'h400;
    localparam axi_addr_t CTRL_ADDR = 12'h800;
    localparam axi_addr_t STAT_ADDR = 12'h804;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // 8x8 tiles, map is 32 columns by 8 rows
    localparam int TILE_SHIFT   = 3;
    localparam int MAP_COL_BITS = 5;
    localparam int MAP_ROW_BITS = 3;

endpackage

//--- src/video_subsys.sv
//////////////////////////////
// Video subsystem top
// Register front end and pixel pipeline
//////////////////////////////
module video_subsys #(
    parameter int H_ACTIVE = 320,
    parameter int H_TOTAL  = 400,
    parameter int V_ACTIVE = 240,
    parameter int V_TOTAL  = 262,
    parameter int HS_START = 328,
    parameter int HS_LEN   = 32,
    parameter int VS_START = 244,
    parameter int VS_LEN   = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // AXI4-Lite slave
    input  video_pkg::axi_addr_t  awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  video_pkg::axi_data_t  wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output video_pkg::axi_resp_t  bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  video_pkg::axi_addr_t  araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output video_pkg::axi_data_t  rdata,
    output video_pkg::axi_resp_t  rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // Pixel output
    output video_pkg::rgb_t       rgb,
    output logic                  de,
    output logic                  hsync,
    output logic                  vsync
);

    video_pkg::timing_t  timing;
    video_pkg::pix_idx_t pix;
    video_pkg::vram_wr_t vram_wr;
    video_pkg::vctrl_t   ctrl;
    logic                vblank;

    video_timer #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .HS_START (HS_START),
        .HS_LEN   (HS_LEN),
        .VS_START (VS_START),
        .VS_LEN   (VS_LEN)
    ) u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .timing (timing),
        .vblank (vblank)
    );

    axil_vregs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .vblank  (vblank),
        .vram_wr (vram_wr),
        .ctrl    (ctrl)
    );

    // Two cycles from timer to colour index
    tile_render #(
        .H_ACTIVE (H_ACTIVE)
    ) u_render (
        .clk       (clk),
        .rst_n     (rst_n),
        .timing_in (timing),
        .ctrl      (ctrl),
        .vram_wr   (vram_wr),
        .pix_out   (pix)
    );

    // Two more cycles to RGB
    colour_mix u_mix (
        .clk     (clk),
        .rst_n   (rst_n),
        .pix_in  (pix),
        .ctrl    (ctrl),
        .vram_wr (vram_wr),
        .rgb     (rgb),
        .de      (de),
        .hsync   (hsync),
        .vsync   (vsync)
    );

endmodule

//--- src/video_timer.sv
//////////////////////////////
// Video timing generator
// Pixel counters, blanking and sync
//////////////////////////////
module video_timer #(
    parameter int H_ACTIVE = 320,
    parameter int H_TOTAL  = 400,
    parameter int V_ACTIVE = 240,
    parameter int V_TOTAL  = 262,
    parameter int HS_START = 328,
    parameter int HS_LEN   = 32,
    parameter int VS_START = 244,
    parameter int VS_LEN   = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    output video_pkg::timing_t timing,
    output logic               vblank
);

    video_pkg::coord_t x_nxt;
    video_pkg::coord_t y_nxt;
    logic              line_end;
    logic              frame_end;

    assign line_end  = timing.x == video_pkg::coord_t'(H_TOTAL - 1);
    assign frame_end = timing.y == video_pkg::coord_t'(V_TOTAL - 1);

    // Next position, y steps only at the end of a line
    always_comb begin
        x_nxt = line_end ? '0 : timing.x + 1'b1;
        y_nxt = timing.y;
        if (line_end) begin
            y_nxt = frame_end ? '0 : timing.y + 1'b1;
        end
    end

    // Flags are derived from the next position so they match x and y
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timing <= '0;
        end else begin
            timing.x     <= x_nxt;
            timing.y     <= y_nxt;
            timing.de    <= (x_nxt < video_pkg::coord_t'(H_ACTIVE)) &&
                            (y_nxt < video_pkg::coord_t'(V_ACTIVE));
            timing.hsync <= (x_nxt >= video_pkg::coord_t'(HS_START)) &&
                            (x_nxt <  video_pkg::coord_t'(HS_START + HS_LEN));
            timing.vsync <= (y_nxt >= video_pkg::coord_t'(VS_START)) &&
                            (y_nxt <  video_pkg::coord_t'(VS_START + VS_LEN));
        end
    end

    // Vertical blank seen by the CPU status register
    assign vblank = timing.y >= video_pkg::coord_t'(V_ACTIVE);

    a_x_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        timing.x < video_pkg::coord_t'(H_TOTAL)
    ) else $error("x counter beyond line length");

endmodule

//--- tb/tb_clock.sv
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
module tb_clock (
    output logic clk,
    output logic rst_n
);

    // Period of 40 time units
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset low for the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb/tb_video_subsys.sv
//////////////////////////////
// Video subsystem testbench
// Bus setup, frame and pixel checks
//////////////////////////////
module tb_video_subsys;

    localparam int H_ACTIVE = 40;
    localparam int H_TOTAL  = 52;
    localparam int V_ACTIVE = 16;
    localparam int V_TOTAL  = 22;
    localparam int LIMIT    = 4000;

    logic                 clk;
    logic                 rst_n;
    video_pkg::axi_addr_t awaddr;
    logic                 awvalid;
    logic                 awready;
    video_pkg::axi_data_t wdata;
    logic                 wvalid;
    logic                 wready;
    video_pkg::axi_resp_t bresp;
    logic                 bvalid;
    logic                 bready;
    video_pkg::axi_addr_t araddr;
    logic                 arvalid;
    logic                 arready;
    video_pkg::axi_data_t rdata;
    video_pkg::axi_resp_t rresp;
    logic                 rvalid;
    logic                 rready;
    video_pkg::rgb_t      rgb;
    logic                 de;
    logic                 hsync;
    logic                 vsync;

    // Model of what the CPU has programmed
    video_pkg::tile_entry_t map_m [256];
    video_pkg::rgb_t        pal_m [16];
    logic [7:0]             scroll_m;
    logic                   flip_m;
    logic                   layer_m;

    // Expected answers for the next bus responses
    video_pkg::axi_resp_t   exp_bresp;
    video_pkg::axi_resp_t   exp_rresp;
    video_pkg::axi_data_t   exp_rdata;

    // Position tracking at the outputs
    logic            hs_q;
    logic            vs_q;
    logic            de_q;
    logic            hs_seen;
    logic            vs_seen;
    logic            pos_valid;
    logic            check_en;
    int              hs_cnt;
    int              vs_cnt;
    int              line_cnt;
    int              pix_cnt;
    int              seed;
    video_pkg::rgb_t exp_rgb;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    video_subsys #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .HS_START (42),
        .HS_LEN   (4),
        .VS_START (18),
        .VS_LEN   (2)
    ) uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rgb     (rgb),
        .de      (de),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    task automatic fail_stop(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Reference colour for the n-th active pixel of a frame
    function automatic video_pkg::rgb_t model_pixel(input int n);
        int                     x;
        int                     y;
        int                     u;
        int                     entry_idx;
        video_pkg::tile_entry_t entry;
        video_pkg::col_idx_t    idx;
        x = n % H_ACTIVE;
        y = n / H_ACTIVE;
        // Mirror first, then scroll, wrapping at the map width
        u = ((flip_m ? H_ACTIVE - 1 - x : x) + int'(scroll_m)) % 256;
        entry_idx = (y >> 3) * 32 + (u >> 3);
        entry = map_m[8'(entry_idx)];
        idx = (((u ^ y) >> 2) & 1) != 0 ? entry[7:4] : entry[3:0];
        return layer_m ? pal_m[idx] : pal_m[0];
    endfunction

    always_comb begin
        exp_rgb = model_pixel(pix_cnt);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            de_q      <= 1'b0;
            hs_seen   <= 1'b0;
            vs_seen   <= 1'b0;
            pos_valid <= 1'b0;
            hs_cnt    <= 0;
            vs_cnt    <= 0;
            line_cnt  <= 0;
            pix_cnt   <= 0;
        end else begin
            hs_q     <= hsync;
            vs_q     <= vsync;
            de_q     <= de;
            hs_cnt   <= (hsync && !hs_q) ? 1 : hs_cnt + 1;
            vs_cnt   <= (vsync && !vs_q) ? 1 : vs_cnt + 1;
            line_cnt <= de ? line_cnt + 1 : 0;
            if (hsync && !hs_q) begin
                hs_seen <= 1'b1;
            end
            if (vsync && !vs_q) begin
                vs_seen <= 1'b1;
            end
            // Pixel count restarts when vsync falls
            if (vs_q && !vsync) begin
                pix_cnt   <= 0;
                pos_valid <= 1'b1;
            end else if (de) begin
                pix_cnt <= pix_cnt + 1;
            end
        end
    end

    a_hs_period: assert property (@(posedge clk) disable iff (!rst_n)
        hsync && !hs_q && hs_seen |-> hs_cnt == H_TOTAL)
        else fail_stop($sformatf("Fail %0t hsync period got %0d expected %0d",
                                 $time, $sampled(hs_cnt), H_TOTAL));

    a_vs_period: assert property (@(posedge clk) disable iff (!rst_n)
        vsync && !vs_q && vs_seen |-> vs_cnt == H_TOTAL * V_TOTAL)
        else fail_stop($sformatf("Fail %0t vsync period got %0d expected %0d",
                                 $time, $sampled(vs_cnt), H_TOTAL * V_TOTAL));

    // First line after reset starts at x of one, so lines count after an hsync
    a_line_len: assert property (@(posedge clk) disable iff (!rst_n)
        de_q && !de && hs_seen |-> line_cnt == H_ACTIVE)
        else fail_stop($sformatf("Fail %0t de line length got %0d expected %0d",
                                 $time, $sampled(line_cnt), H_ACTIVE));

    a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
        vsync && !vs_q && pos_valid |-> pix_cnt == H_ACTIVE * V_ACTIVE)
        else fail_stop($sformatf("Fail %0t de pixels per frame got %0d expected %0d",
                                 $time, $sampled(pix_cnt), H_ACTIVE * V_ACTIVE));

    a_pixel: assert property (@(posedge clk) disable iff (!rst_n)
        de && check_en |-> rgb == exp_rgb)
        else fail_stop($sformatf("Fail %0t rgb got %h expected %h at pixel %0d",
                                 $time, $sampled(rgb), $sampled(exp_rgb),
                                 $sampled(pix_cnt)));

    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !de |-> rgb == '0)
        else fail_stop($sformatf("Fail %0t rgb got %h expected 0 while de is low",
                                 $time, $sampled(rgb)));

    a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && bready |-> bresp == exp_bresp)
        else fail_stop($sformatf("Fail %0t bresp got %0d expected %0d",
                                 $time, $sampled(bresp), $sampled(exp_bresp)));

    a_bhold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else fail_stop("bvalid dropped while bready was still low");

    a_rresp: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rresp == exp_rresp)
        else fail_stop($sformatf("Fail %0t rresp got %0d expected %0d",
                                 $time, $sampled(rresp), $sampled(exp_rresp)));

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rdata == exp_rdata)
        else fail_stop($sformatf("Fail %0t rdata got %h expected %h",
                                 $time, $sampled(rdata), $sampled(exp_rdata)));

    task automatic wait_reset();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rst_n && n < LIMIT);
        if (!rst_n) fail_stop("reset was never released");
    endtask

    // Hold bready low for hold cycles after the write is taken
    task automatic axi_write(input video_pkg::axi_addr_t addr, input video_pkg::axi_data_t data,
                             input video_pkg::axi_resp_t resp, input int hold);
        int   n;
        logic got;
        @(posedge clk);
        awaddr    <= addr;
        wdata     <= data;
        awvalid   <= 1'b1;
        wvalid    <= 1'b1;
        bready    <= (hold == 0);
        exp_bresp <= resp;
        n = 0;
        do begin
            @(posedge clk);
            got = awready && wready;
            n++;
        end while (!got && n < LIMIT);
        if (!got) fail_stop("write address and data were never accepted");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (hold) @(posedge clk);
        bready <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            got = bvalid && bready;
            n++;
        end while (!got && n < LIMIT);
        if (!got) fail_stop("write response never arrived");
        bready <= 1'b0;
    endtask

    task automatic axi_read(input video_pkg::axi_addr_t addr, input video_pkg::axi_resp_t resp,
                            input video_pkg::axi_data_t data);
        int   n;
        logic got;
        @(posedge clk);
        araddr    <= addr;
        arvalid   <= 1'b1;
        rready    <= 1'b1;
        exp_rresp <= resp;
        exp_rdata <= data;
        n = 0;
        do begin
            @(posedge clk);
            got = arready;
            n++;
        end while (!got && n < LIMIT);
        if (!got) fail_stop("read address was never accepted");
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            got = rvalid && rready;
            n++;
        end while (!got && n < LIMIT);
        if (!got) fail_stop("read data never arrived");
        rready <= 1'b0;
    endtask

    // Control word is {layer_en, flip, scroll_x} in bits 9:0
    task automatic set_ctrl(input logic [7:0] scroll, input logic flip, input logic layer,
                            input int hold);
        axi_write(video_pkg::CTRL_ADDR, {22'd0, layer, flip, scroll},
                  video_pkg::RESP_OKAY, hold);
        scroll_m = scroll;
        flip_m   = flip;
        layer_m  = layer;
        axi_read(video_pkg::CTRL_ADDR, video_pkg::RESP_OKAY, {22'd0, layer, flip, scroll});
    endtask

    task automatic wait_vsync(input logic rising);
        int   n;
        logic got;
        n = 0;
        do begin
            @(posedge clk);
            got = rising ? (vsync && !vs_q) : (vs_q && !vsync);
            n++;
        end while (!got && n < LIMIT);
        if (!got) fail_stop("vsync edge never came");
    endtask

    task automatic wait_pixel(input int target);
        int   n;
        logic got;
        n = 0;
        do begin
            @(posedge clk);
            got = de && pos_valid && pix_cnt == target;
            n++;
        end while (!got && n < LIMIT);
        if (!got) fail_stop("active pixel position never reached");
    endtask

    // Compare one whole frame drawn after the last setup change
    task automatic check_frame();
        wait_vsync(1'b0);
        check_en <= 1'b1;
        wait_vsync(1'b1);
        check_en <= 1'b0;
    endtask

    initial begin
        int i;
        awaddr    <= '0;
        awvalid   <= 1'b0;
        wdata     <= '0;
        wvalid    <= 1'b0;
        bready    <= 1'b0;
        araddr    <= '0;
        arvalid   <= 1'b0;
        rready    <= 1'b0;
        check_en  <= 1'b0;
        exp_bresp <= '0;
        exp_rresp <= '0;
        exp_rdata <= '0;
        scroll_m  = '0;
        flip_m    = 1'b0;
        layer_m   = 1'b0;
        seed = $urandom(32'h42d7);
        wait_reset();

        // Random tile map and palette
        for (i = 0; i < 256; i++) begin
            map_m[i] = video_pkg::tile_entry_t'($urandom);
            axi_write(video_pkg::MAP_BASE + 12'(i * 4), {24'd0, map_m[i]},
                      video_pkg::RESP_OKAY, 0);
        end
        for (i = 0; i < 16; i++) begin
            pal_m[i] = video_pkg::rgb_t'($urandom);
            axi_write(video_pkg::PAL_BASE + 12'(i * 4), {17'd0, pal_m[i]},
                      video_pkg::RESP_OKAY, 0);
        end

        set_ctrl(8'd0, 1'b0, 1'b1, 0);
        check_frame();

        // Bus error paths
        axi_write(12'hC00, $urandom, video_pkg::RESP_SLVERR, 0);
        axi_write(video_pkg::STAT_ADDR, 32'd1, video_pkg::RESP_SLVERR, 0);
        axi_read(12'h100, video_pkg::RESP_SLVERR, 32'd0);
        axi_read(12'hC04, video_pkg::RESP_SLVERR, 32'd0);

        // Scroll, written with a stalled response
        set_ctrl(8'd93, 1'b0, 1'b1, 5);
        check_frame();
        set_ctrl(8'd21, 1'b1, 1'b1, 0);
        check_frame();
        // Layer off shows the backdrop only
        set_ctrl(8'd21, 1'b1, 1'b0, 0);
        check_frame();

        // Status inside vsync, then in the middle of line 8
        wait_vsync(1'b1);
        axi_read(video_pkg::STAT_ADDR, video_pkg::RESP_OKAY, 32'd1);
        wait_pixel(8 * H_ACTIVE + H_ACTIVE / 2);
        axi_read(video_pkg::STAT_ADDR, video_pkg::RESP_OKAY, 32'd0);

        repeat (4) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- video_subsys.f
src/video_pkg.sv
src/video_timer.sv
src/axil_vregs.sv
src/tile_render.sv
src/colour_mix.sv
src/video_subsys.sv
tb/tb_clock.sv
tb/tb_video_subsys.sv
